/* sources.f */
xge_rx_pkg.sv
xge_frame_buf.sv
xge_rx_store.sv
xge_rx_crc.sv
xge_rx_commit.sv
xge_rx_drain.sv
xge_rx_top.sv
tb_xge_rx_top.sv

/* tb_xge_rx_top.sv */
`timescale 1ns/1ps

module tb_xge_rx_top;
    import xge_rx_pkg::*;

    logic              clk;
    logic              rst;
    logic [XGE_DW-1:0] in_data;
    logic [XGE_KW-1:0] in_keep;
    logic              in_valid;
    logic              in_last;
    logic              out_ready;
    logic [XGE_DW-1:0] out_data;
    logic [XGE_KW-1:0] out_keep;
    logic              out_last;
    logic              out_valid;
    logic [CNT_W-1:0]  frames_ok;
    logic [CNT_W-1:0]  frames_crc_err;
    logic [CNT_W-1:0]  frames_ovf;

    logic [31:0] lfsr = 32'h7647_8600;
    int          ready_mode = 0;     // 0 always, 1 random 3/4, 2 held low
    bit          loose = 0;          // overflow phase where output may skip good frames
    int          cyc = 0;
    int          in_words = 0;
    int          sent = 0;
    int          sent_bad = 0;
    int          rx_frames = 0;

    // good frames still expected
    // words flat plus per-frame length and last keep
    logic [XGE_DW-1:0] exp_words [$];
    int                exp_nw [$];
    logic [XGE_KW-1:0] exp_lkeep [$];
    // frame being collected at the output
    logic [XGE_DW-1:0] cur_words [$];
    logic [XGE_KW-1:0] cur_lkeep;
    logic              stall_q;
    logic [XGE_DW-1:0] data_q;
    logic [XGE_KW-1:0] keep_q;
    logic              last_q;

    xge_rx_top i_dut (
        .clk(clk), .rst(rst), .in_data(in_data), .in_keep(in_keep),
        .in_valid(in_valid), .in_last(in_last), .out_ready(out_ready),
        .out_data(out_data), .out_keep(out_keep), .out_last(out_last),
        .out_valid(out_valid), .frames_ok(frames_ok),
        .frames_crc_err(frames_crc_err), .frames_ovf(frames_ovf)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ///////////////////////////////////////////////////////////////////////
    // helpers
    ///////////////////////////////////////////////////////////////////////
    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // reflected crc-32 bit by bit with lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int k = 0; k < 8; k++) begin
            r = (r[0] ^ b[k]) ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        $display("error at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // one clock of input plus the out_ready for it
    task automatic drive_word(input logic v, input logic [63:0] d, input logic [7:0] k,
                              input logic l);
        @(posedge clk);
        in_valid <= v;
        in_data  <= d;
        in_keep  <= k;
        in_last  <= l;
        case (ready_mode)
            0: out_ready <= 1'b1;
            1: out_ready <= (rand_bits(2) != 0);
            default: out_ready <= 1'b0;
        endcase
    endtask

    task automatic send_frame(input bit allow_bad);
        logic [7:0]  frm [256];
        logic [31:0] c;
        logic [63:0] w;
        logic [7:0]  k;
        int          len;
        int          nw;
        int          gap;
        int          pos;
        bit          bad;
        len = 8 + (rand_bits(8) % 193);
        gap = 2 + rand_bits(3);
        bad = allow_bad && (rand_bits(2) == 0);
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < len - 4; i++) begin
            frm[i] = rand_bits(8);
            c = crc_byte(c, frm[i]);
        end
        c = ~c;                                       // fcs goes out lsb byte first
        for (int i = 0; i < 4; i++) frm[len-4+i] = c[8*i +: 8];
        if (bad) begin
            pos = rand_bits(11) % (len * 8);
            frm[pos/8][pos%8] = ~frm[pos/8][pos%8];
        end
        nw = (len + 7) / 8;
        for (int j = 0; j < nw; j++) begin
            w = '0;
            k = '0;
            for (int b = 0; b < 8; b++) begin
                if (8*j + b < len) begin
                    w[8*b +: 8] = frm[8*j + b];
                    k[b] = 1'b1;
                end
            end
            if (!bad) exp_words.push_back(w);
            drive_word(1'b1, w, k, j == nw - 1);
            if (j == nw - 1 && !bad) exp_lkeep.push_back(k);
        end
        if (!bad) exp_nw.push_back(nw);
        sent++;
        in_words += nw;
        if (bad) sent_bad++;
        for (int g = 0; g < gap; g++) drive_word(1'b0, '0, '0, 1'b0);
    endtask

    // true when the collected frame equals the head expected frame
    function automatic bit head_matches();
        if (exp_nw.size() == 0 || exp_nw[0] != cur_words.size()) return 0;
        if (exp_lkeep[0] != cur_lkeep) return 0;
        for (int i = 0; i < exp_nw[0]; i++) begin
            if (exp_words[i] != cur_words[i]) return 0;
        end
        return 1;
    endfunction

    task automatic drop_head();
        for (int i = 0; i < exp_nw[0]; i++) void'(exp_words.pop_front());
        void'(exp_nw.pop_front());
        void'(exp_lkeep.pop_front());
    endtask

    ///////////////////////////////////////////////////////////////////////
    // output monitor and scoreboard
    ///////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > in_words * 4 + 2000) begin
            $display("timeout after %0d cycles, limit set by %0d input words", cyc, in_words);
            $display("STATUS: FAIL");
            $fatal(1);
        end
        if (!rst && stall_q) begin  // held word must not move
            assert (out_valid) else report_failure("out_valid dropped while stalled");
            assert (out_data == data_q) else report_mismatch("out_data", data_q, out_data);
            assert (out_keep == keep_q) else report_mismatch("out_keep", keep_q, out_keep);
            assert (out_last == last_q) else report_mismatch("out_last", last_q, out_last);
        end
        stall_q <= !rst && out_valid && !out_ready;
        data_q  <= out_data;
        keep_q  <= out_keep;
        last_q  <= out_last;
        if (!rst && out_valid && out_ready) begin
            cur_words.push_back(out_data);
            if (!out_last) begin
                assert (out_keep == 8'hFF) else report_mismatch("out_keep", 8'hFF, out_keep);
            end else begin
                cur_lkeep = out_keep;
                if (loose) begin
                    while (exp_nw.size() != 0 && !head_matches()) drop_head();
                    assert (exp_nw.size() != 0)
                        else report_failure("output frame is not among the good frames sent");
                end else begin
                    assert (exp_nw.size() != 0) else report_failure("unexpected output frame");
                    assert (cur_words.size() == exp_nw[0])
                        else report_mismatch("frame words", exp_nw[0], cur_words.size());
                    for (int i = 0; i < exp_nw[0]; i++) begin
                        assert (cur_words[i] == exp_words[i])
                            else report_mismatch("out_data", exp_words[i], cur_words[i]);
                    end
                    assert (cur_lkeep == exp_lkeep[0])
                        else report_mismatch("out_keep", exp_lkeep[0], cur_lkeep);
                end
                drop_head();
                cur_words.delete();
                rx_frames++;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // test sequence
    ///////////////////////////////////////////////////////////////////////
    initial begin
        rst       = 1'b1;
        in_data   = '0;
        in_keep   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin  // registers are unknown before the first reset edge
                assert (!out_valid) else report_mismatch("out_valid", 0, out_valid);
                assert (frames_ok == 0) else report_mismatch("frames_ok", 0, frames_ok);
                assert (frames_crc_err == 0)
                    else report_mismatch("frames_crc_err", 0, frames_crc_err);
                assert (frames_ovf == 0) else report_mismatch("frames_ovf", 0, frames_ovf);
            end
        end
        rst <= 1'b0;
        drive_word(1'b0, '0, '0, 1'b0);
        assert (!out_valid && frames_ok == 0 && frames_crc_err == 0 && frames_ovf == 0)
            else report_failure("outputs not in reset state after reset");

        // clean frames with free-flowing output
        for (int i = 0; i < 20; i++) send_frame(0);
        // crc errors with random back-pressure
        ready_mode = 1;
        for (int i = 0; i < 60; i++) send_frame(1);
        while (exp_nw.size() != 0) drive_word(1'b0, '0, '0, 1'b0);
        repeat (4) drive_word(1'b0, '0, '0, 1'b0);
        assert (frames_crc_err == sent_bad)
            else report_mismatch("frames_crc_err", sent_bad, frames_crc_err);
        assert (frames_ovf == 0) else report_mismatch("frames_ovf", 0, frames_ovf);
        assert (frames_ok == sent - sent_bad)
            else report_mismatch("frames_ok", sent - sent_bad, frames_ok);

        // overflow with the output blocked while frames keep coming
        loose      = 1;
        ready_mode = 2;
        for (int i = 0; i < 30; i++) send_frame(1);
        ready_mode = 0;
        repeat (4) drive_word(1'b0, '0, '0, 1'b0);  // last descriptor now visible
        while (out_valid) drive_word(1'b0, '0, '0, 1'b0);
        assert (frames_ovf != 0) else report_failure("overflow phase caused no overflow");
        assert (frames_ok == rx_frames) else report_mismatch("frames_ok", rx_frames, frames_ok);
        assert (frames_ok + frames_crc_err + frames_ovf == sent)
            else report_mismatch("frame total", sent,
                                 frames_ok + frames_crc_err + frames_ovf);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* xge_frame_buf.sv */
`timescale 1ns/1ps

module xge_frame_buf #(
    parameter int AW = 9
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [AW-1:0]                 wr_addr,
    input  logic [xge_rx_pkg::XGE_DW-1:0] wr_data,
    input  logic [AW-1:0]                 rd_addr,
    output logic [xge_rx_pkg::XGE_DW-1:0] rd_data
);
    import xge_rx_pkg::*;

    logic [XGE_DW-1:0] mem [2**AW];

    // write port staging, helps timing into the ram
    logic              wr_en_q;
    logic [AW-1:0]     wr_addr_q;
    logic [XGE_DW-1:0] wr_data_q;

    ///////////////////////////////////////////////////////////////////////
    // write side, lands two edges after the inputs
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        wr_en_q   <= wr_en;
        wr_addr_q <= wr_addr;
        wr_data_q <= wr_data;
        if (wr_en_q) begin
            mem[wr_addr_q] <= wr_data_q;
        end
    end

    // read side, registered output, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* xge_rx_commit.sv */
`timescale 1ns/1ps

module xge_rx_commit #(
    parameter int AW      = 9,
    parameter int DESC_AW = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          st_done,
    input  logic                          st_ovf,
    input  logic [AW:0]                   st_words,
    input  logic [xge_rx_pkg::XGE_KW-1:0] st_last_keep,
    input  logic                          crc_done,
    input  logic                          crc_ok,
    input  logic                          desc_pop,
    output logic                          commit,
    output logic                          rewind,
    output logic                          desc_valid,
    output logic [AW:0]                   desc_words,
    output logic [xge_rx_pkg::XGE_KW-1:0] desc_last_keep,
    output logic [xge_rx_pkg::CNT_W-1:0]  frames_ok,
    output logic [xge_rx_pkg::CNT_W-1:0]  frames_crc_err,
    output logic [xge_rx_pkg::CNT_W-1:0]  frames_ovf
);
    import xge_rx_pkg::*;

    localparam int DEPTH = 2**DESC_AW;

    // descriptor fifo, words and last keep per frame
    logic [AW:0]        d_words [DEPTH];
    logic [XGE_KW-1:0]  d_keep  [DEPTH];
    logic [DESC_AW-1:0] d_wp;
    logic [DESC_AW-1:0] d_rp;
    logic [DESC_AW:0]   d_cnt;

    logic frm_done;
    logic full;
    logic accept;

    assign frm_done = st_done & crc_done;             // both land on the same cycle
    assign full     = d_cnt[DESC_AW];
    assign accept   = frm_done & ~st_ovf & crc_ok & ~full;

    ///////////////////////////////////////////////////////////////////////
    // decision and counters
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            commit         <= 1'b0;
            rewind         <= 1'b0;
            frames_ok      <= '0;
            frames_crc_err <= '0;
            frames_ovf     <= '0;
        end else begin
            commit <= accept;
            rewind <= frm_done & ~accept;
            if (accept) begin
                frames_ok <= frames_ok + 1'b1;
            end else if (frm_done && (st_ovf || full)) begin
                frames_ovf <= frames_ovf + 1'b1;  // wins over a bad crc
            end else if (frm_done) begin
                frames_crc_err <= frames_crc_err + 1'b1;
            end
        end
    end

    // entry written now, made visible by the commit pulse a cycle later
    always_ff @(posedge clk) begin
        if (accept) begin
            d_words[d_wp] <= st_words;
            d_keep[d_wp]  <= st_last_keep;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_wp  <= '0;
            d_rp  <= '0;
            d_cnt <= '0;
        end else begin
            if (commit)   d_wp <= d_wp + 1'b1;
            if (desc_pop) d_rp <= d_rp + 1'b1;
            d_cnt <= d_cnt + commit - desc_pop;
        end
    end

    assign desc_valid     = d_cnt != '0;
    assign desc_words     = d_words[d_rp];
    assign desc_last_keep = d_keep[d_rp];

endmodule

/* xge_rx_crc.sv */
`timescale 1ns/1ps

module xge_rx_crc (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [xge_rx_pkg::XGE_DW-1:0] in_data,
    input  logic [xge_rx_pkg::XGE_KW-1:0] in_keep,
    input  logic                          in_valid,
    input  logic                          in_last,
    output logic                          crc_done,
    output logic                          crc_ok
);
    import xge_rx_pkg::*;

    logic [31:0] crc_q;     // running remainder
    logic [31:0] crc_seed;
    logic [31:0] crc_next;
    logic        sof;       // next valid word opens a frame

    ///////////////////////////////////////////////////////////////////////
    // byte-serial reflected crc, unrolled over one word
    ///////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] crc_word(
        input logic [31:0]       seed,
        input logic [XGE_DW-1:0] data,
        input logic [XGE_KW-1:0] keep
    );
        logic [31:0] c;
        logic [3:0]  n;
        c = seed;
        n = keep_bytes(keep);
        for (int b = 0; b < XGE_KW; b++) begin
            if (b < n) begin  // lsb byte goes first
                c = c ^ {24'd0, data[8*b +: 8]};
                for (int k = 0; k < 8; k++) begin
                    c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
                end
            end
        end
        return c;
    endfunction

    assign crc_seed = sof ? CRC32_INIT : crc_q;
    assign crc_next = crc_word(crc_seed, in_data, in_keep);

    always_ff @(posedge clk) begin
        if (rst) begin
            sof      <= 1'b1;
            crc_done <= 1'b0;
            crc_ok   <= 1'b0;
        end else begin
            crc_done <= 1'b0;
            if (in_valid) begin
                sof <= in_last;
                if (in_last) begin
                    crc_done <= 1'b1;
                    // no final inversion, so a good frame leaves the residue
                    crc_ok   <= (crc_next == CRC32_RESIDUE);
                end
            end
        end
    end

    // remainder only matters between sof and last
    always_ff @(posedge clk) begin
        if (in_valid) begin
            crc_q <= crc_next;
        end
    end

endmodule

/* xge_rx_drain.sv */
`timescale 1ns/1ps

module xge_rx_drain #(
    parameter int AW = 9
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          desc_valid,
    input  logic [AW:0]                   desc_words,
    input  logic [xge_rx_pkg::XGE_KW-1:0] desc_last_keep,
    input  logic [xge_rx_pkg::XGE_DW-1:0] rd_data,
    input  logic                          out_ready,
    output logic                          desc_pop,
    output logic [AW-1:0]                 rd_addr,
    output logic [AW-1:0]                 rd_ptr,
    output logic [xge_rx_pkg::XGE_DW-1:0] out_data,
    output logic [xge_rx_pkg::XGE_KW-1:0] out_keep,
    output logic                          out_last,
    output logic                          out_valid
);
    import xge_rx_pkg::*;

    logic [AW:0]       word_idx;   // words issued from head descriptor
    logic              is_last;
    logic              issue;
    logic              out_pop;

    // read in flight, data shows on rd_data this cycle
    logic              pend;
    logic              pend_last;
    logic [XGE_KW-1:0] pend_keep;

    // two-entry output buffer
    logic [XGE_DW-1:0] ob_data [2];
    logic [XGE_KW-1:0] ob_keep [2];
    logic              ob_last [2];
    logic              ob_wp;
    logic              ob_rp;
    logic [1:0]        ob_cnt;
    logic [1:0]        fill;

    assign out_pop = out_valid & out_ready;
    assign fill    = ob_cnt + pend;                  // never above 2
    assign is_last = (word_idx + 1'b1) == desc_words;
    assign issue   = desc_valid & ((fill < 2'd2) | out_pop);
    assign desc_pop = issue & is_last;               // head done once fully issued

    ///////////////////////////////////////////////////////////////////////
    // read issue
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr  <= '0;
            rd_ptr   <= '0;
            word_idx <= '0;
            pend     <= 1'b0;
        end else begin
            pend <= issue;
            if (issue) begin
                rd_addr  <= rd_addr + 1'b1;
                word_idx <= is_last ? '0 : word_idx + 1'b1;
            end
            if (out_pop) rd_ptr <= rd_ptr + 1'b1;    // slot free for the store
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pend_last <= is_last;
            pend_keep <= is_last ? desc_last_keep : '1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // output buffer
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pend) begin
            ob_data[ob_wp] <= rd_data;
            ob_keep[ob_wp] <= pend_keep;
            ob_last[ob_wp] <= pend_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ob_wp  <= 1'b0;
            ob_rp  <= 1'b0;
            ob_cnt <= 2'd0;
        end else begin
            if (pend)    ob_wp <= ~ob_wp;
            if (out_pop) ob_rp <= ~ob_rp;
            ob_cnt <= ob_cnt + pend - out_pop;
        end
    end

    // head entry holds still while stalled
    assign out_valid = ob_cnt != 2'd0;
    assign out_data  = ob_data[ob_rp];
    assign out_keep  = ob_keep[ob_rp];
    assign out_last  = ob_last[ob_rp];

endmodule

/* xge_rx_pkg.sv */
package xge_rx_pkg;

    ///////////////////////////////////////////////////////////////////////
    // stream widths
    ///////////////////////////////////////////////////////////////////////
    localparam int XGE_DW = 64;                       // data word
    localparam int XGE_KW = XGE_DW / 8;               // one valid bit per byte

    ///////////////////////////////////////////////////////////////////////
    // crc-32 constants, reflected form
    ///////////////////////////////////////////////////////////////////////
    localparam logic [31:0] CRC32_POLY    = 32'hEDB8_8320; // 04C11DB7 bit-reversed
    localparam logic [31:0] CRC32_INIT    = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC32_RESIDUE = 32'hDEBB_20E3; // good frame incl. fcs

    localparam int CNT_W = 32;                        // frame counters

    // number of valid bytes in a keep word, 1 to 8
    // keep is contiguous from bit 0, so a plain popcount does it
    function automatic logic [3:0] keep_bytes(input logic [XGE_KW-1:0] keep);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < XGE_KW; i++) begin
            if (keep[i]) begin
                n = n + 4'd1;
            end
        end
        return n;
    endfunction

endpackage

/* xge_rx_store.sv */
`timescale 1ns/1ps

module xge_rx_store #(
    parameter int AW = 9
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [xge_rx_pkg::XGE_DW-1:0] in_data,
    input  logic [xge_rx_pkg::XGE_KW-1:0] in_keep,
    input  logic                          in_valid,
    input  logic                          in_last,
    input  logic                          commit,
    input  logic                          rewind,
    input  logic [AW-1:0]                 rd_ptr,
    output logic                          wr_en,
    output logic [AW-1:0]                 wr_addr,
    output logic [xge_rx_pkg::XGE_DW-1:0] wr_data,
    output logic                          st_done,
    output logic                          st_ovf,
    output logic [AW:0]                   st_words,
    output logic [xge_rx_pkg::XGE_KW-1:0] st_last_keep
);
    import xge_rx_pkg::*;

    logic [AW-1:0] wr_ptr;     // next free word
    logic [AW-1:0] frm_start;  // first word of frame in progress
    logic [AW:0]   word_cnt;   // words seen so far in this frame
    logic          ovf;        // sticky for the current frame
    logic          space;
    logic          ovf_now;

    assign space   = (wr_ptr + 1'b1) != rd_ptr; // one slot always kept empty
    assign ovf_now = ovf | ~space;

    ///////////////////////////////////////////////////////////////////////
    // pointers and frame tracking
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en     <= 1'b0;
            st_done   <= 1'b0;
            wr_ptr    <= '0;
            frm_start <= '0;
            word_cnt  <= '0;
            ovf       <= 1'b0;
        end else begin
            wr_en   <= 1'b0;
            st_done <= 1'b0;
            if (in_valid) begin
                if (!ovf_now) begin
                    wr_en  <= 1'b1;
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (in_last) begin  // close the frame, restart tracking
                    st_done  <= 1'b1;
                    word_cnt <= '0;
                    ovf      <= 1'b0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                    ovf      <= ovf_now;
                end
            end
            if (commit) frm_start <= wr_ptr;   // frame kept
            if (rewind) wr_ptr    <= frm_start; // frame dropped
        end
    end

    // frame result and write payload
    always_ff @(posedge clk) begin
        wr_addr <= wr_ptr;
        wr_data <= in_data;
        if (in_valid && in_last) begin
            st_ovf       <= ovf_now;
            st_words     <= word_cnt + 1'b1;
            st_last_keep <= in_keep;
        end
    end

endmodule

/* xge_rx_top.sv */
`timescale 1ns/1ps

module xge_rx_top #(
    parameter int BUF_AW  = 9,   // 512 words
    parameter int DESC_AW = 3    // 8 frames
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [xge_rx_pkg::XGE_DW-1:0] in_data,
    input  logic [xge_rx_pkg::XGE_KW-1:0] in_keep,
    input  logic                          in_valid,
    input  logic                          in_last,
    input  logic                          out_ready,
    output logic [xge_rx_pkg::XGE_DW-1:0] out_data,
    output logic [xge_rx_pkg::XGE_KW-1:0] out_keep,
    output logic                          out_last,
    output logic                          out_valid,
    output logic [xge_rx_pkg::CNT_W-1:0]  frames_ok,
    output logic [xge_rx_pkg::CNT_W-1:0]  frames_crc_err,
    output logic [xge_rx_pkg::CNT_W-1:0]  frames_ovf
);
    import xge_rx_pkg::*;

    // buffer ports
    logic              wr_en;
    logic [BUF_AW-1:0] wr_addr;
    logic [XGE_DW-1:0] wr_data;
    logic [BUF_AW-1:0] rd_addr;
    logic [XGE_DW-1:0] rd_data;
    logic [BUF_AW-1:0] rd_ptr;

    // frame results
    logic              st_done;
    logic              st_ovf;
    logic [BUF_AW:0]   st_words;
    logic [XGE_KW-1:0] st_last_keep;
    logic              crc_done;
    logic              crc_ok;

    // commit and descriptors
    logic              commit;
    logic              rewind;
    logic              desc_valid;
    logic [BUF_AW:0]   desc_words;
    logic [XGE_KW-1:0] desc_last_keep;
    logic              desc_pop;

    xge_frame_buf #(.AW(BUF_AW)) i_buf (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    xge_rx_store #(.AW(BUF_AW)) i_store (
        .clk(clk), .rst(rst), .in_data(in_data), .in_keep(in_keep),
        .in_valid(in_valid), .in_last(in_last), .commit(commit), .rewind(rewind),
        .rd_ptr(rd_ptr), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .st_done(st_done), .st_ovf(st_ovf), .st_words(st_words),
        .st_last_keep(st_last_keep)
    );

    xge_rx_crc i_crc (
        .clk(clk), .rst(rst), .in_data(in_data), .in_keep(in_keep),
        .in_valid(in_valid), .in_last(in_last), .crc_done(crc_done), .crc_ok(crc_ok)
    );

    xge_rx_commit #(.AW(BUF_AW), .DESC_AW(DESC_AW)) i_commit (
        .clk(clk), .rst(rst), .st_done(st_done), .st_ovf(st_ovf),
        .st_words(st_words), .st_last_keep(st_last_keep), .crc_done(crc_done),
        .crc_ok(crc_ok), .desc_pop(desc_pop), .commit(commit), .rewind(rewind),
        .desc_valid(desc_valid), .desc_words(desc_words),
        .desc_last_keep(desc_last_keep), .frames_ok(frames_ok),
        .frames_crc_err(frames_crc_err), .frames_ovf(frames_ovf)
    );

    xge_rx_drain #(.AW(BUF_AW)) i_drain (
        .clk(clk), .rst(rst), .desc_valid(desc_valid), .desc_words(desc_words),
        .desc_last_keep(desc_last_keep), .rd_data(rd_data), .out_ready(out_ready),
        .desc_pop(desc_pop), .rd_addr(rd_addr), .rd_ptr(rd_ptr),
        .out_data(out_data), .out_keep(out_keep), .out_last(out_last),
        .out_valid(out_valid)
    );

endmodule
